/* logic/boot_pkg.sv */
package boot_pkg;

	// One data or instruction word
	typedef logic [15:0] word_t;

	// Asynchronous SRAM word address
	typedef logic [17:0] ram_addr_t;

	// Word address on the flash pins, bits 22:1
	typedef logic [21:0] flash_addr_t;

	// Active low, bit 0 drives segment a
	typedef logic [6:0] seg_t;

	// Requester payload towards the arbiter
	typedef struct packed {
		ram_addr_t addr;
		word_t     wdata;
	} mem_req_t;

	// Issued instruction and its address
	typedef struct packed {
		word_t pc;
		word_t inst;
	} fetch_out_t;

endpackage

/* logic/flash_reader.sv */
`timescale 1ns/100ps

module flash_reader import boot_pkg::*; #(
	parameter int FLASH_WAIT = 3
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        flash_req,
	input  flash_addr_t flash_addr_req,
	output logic        flash_done,
	output word_t       flash_word,
	output flash_addr_t flash_addr,
	input  word_t       flash_data,
	output logic        flash_ce,
	output logic        flash_oe
);

	localparam int CNT_W = (FLASH_WAIT > 1) ? $clog2(FLASH_WAIT) : 1;

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_capture
	} state_t;

	state_t state;
	logic [CNT_W-1:0] wait_cnt;
	logic last_wait;

	assign last_wait = (state == st_wait) && (wait_cnt == CNT_W'(FLASH_WAIT - 1));

	// Word was latched on the last wait cycle
	assign flash_done = (state == st_capture);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			wait_cnt <= '0;
			flash_ce <= 1'b1;
			flash_oe <= 1'b1;
		end else begin
			case (state)
				st_idle: begin
					wait_cnt <= '0;
					if (flash_req) begin
						flash_ce <= 1'b0;
						flash_oe <= 1'b0;
						state <= st_wait;
					end
				end
				st_wait: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (last_wait)
						state <= st_capture;
				end
				default: begin
					// Chip released once the word is handed back
					flash_ce <= 1'b1;
					flash_oe <= 1'b1;
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && flash_req)
			flash_addr <= flash_addr_req;
		if (last_wait)
			flash_word <= flash_data;
	end

endmodule

/* logic/boot_loader.sv */
`timescale 1ns/100ps

module boot_loader import boot_pkg::*; #(
	parameter int BOOT_WORDS = 64,
	parameter int FLASH_BASE = 0
) (
	input  logic        clk,
	input  logic        rst,
	output logic        flash_req,
	output flash_addr_t flash_addr_req,
	input  logic        flash_done,
	input  word_t       flash_word,
	output logic        wr_req,
	output mem_req_t    wr_bus,
	input  logic        wr_done,
	output ram_addr_t   boot_addr,
	output logic        boot_done
);

	typedef enum logic [1:0] {
		st_read,
		st_write,
		st_done
	} state_t;

	state_t state;
	ram_addr_t word_cnt;
	logic flash_busy;
	logic last_word;

	assign last_word = (word_cnt == ram_addr_t'(BOOT_WORDS - 1));

	assign flash_addr_req = flash_addr_t'(FLASH_BASE) + flash_addr_t'(word_cnt);

	// Flash word stays put until the next read is asked for
	assign wr_bus = '{addr: word_cnt, wdata: flash_word};
	assign wr_req = (state == st_write);

	assign boot_addr = word_cnt;
	assign boot_done = (state == st_done);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_read;
			word_cnt <= '0;
			flash_req <= 1'b0;
			flash_busy <= 1'b0;
		end else begin
			flash_req <= 1'b0;
			case (state)
				st_read: begin
					if (flash_req)
						flash_busy <= 1'b1;
					if (flash_done) begin
						flash_busy <= 1'b0;
						state <= st_write;
					end else if (!flash_busy && !flash_req) begin
						flash_req <= 1'b1;
					end
				end
				st_write: begin
					if (wr_done) begin
						if (last_word) begin
							state <= st_done;
						end else begin
							word_cnt <= word_cnt + 1'b1;
							state <= st_read;
						end
					end
				end
				default: state <= st_done;
			endcase
		end
	end

endmodule

/* logic/inst_fetch.sv */
`timescale 1ns/100ps

module inst_fetch import boot_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       boot_done,
	input  logic       hold,
	input  logic       set_pc,
	input  word_t      set_pc_addr,
	output logic       rd_req,
	output ram_addr_t  rd_addr,
	input  logic       rd_done,
	input  word_t      rd_data,
	output logic       fetch_valid,
	output fetch_out_t fetch,
	output word_t      pc
);

	typedef enum logic [1:0] {
		st_boot,
		st_idle,
		st_read
	} state_t;

	state_t state;
	logic discard;
	logic res_valid;
	logic accept;
	logic issue;

	// Arbiter is idle whenever no read is outstanding here
	assign rd_req = (state == st_idle) && !hold && !set_pc;
	assign rd_addr = ram_addr_t'(pc);

	// A jump drops whatever word comes back with it
	assign accept = rd_done && !discard && !set_pc;
	assign issue = res_valid && !hold && !set_pc;
	assign fetch_valid = issue;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_boot;
			pc <= '0;
			discard <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			case (state)
				st_boot: if (boot_done) state <= st_idle;
				st_idle: if (rd_req) state <= st_read;
				st_read: if (rd_done) state <= st_idle;
				default: state <= st_boot;
			endcase

			if (set_pc)
				pc <= set_pc_addr;
			else if (accept)
				pc <= pc + 1'b1;

			if (rd_done)
				discard <= 1'b0;
			else if (set_pc && state == st_read)
				discard <= 1'b1;

			if (issue || set_pc)
				res_valid <= 1'b0;
			if (accept)
				res_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			fetch <= '{pc: pc, inst: rd_data};
	end

endmodule

/* logic/sram_arbiter.sv */
`timescale 1ns/100ps

module sram_arbiter import boot_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_req,
	input  mem_req_t   wr_bus,
	output logic       wr_done,
	input  logic       rd_req,
	input  ram_addr_t  rd_addr,
	output logic       rd_done,
	output word_t      rd_data,
	output ram_addr_t  ram_addr,
	inout  wire word_t ram_data,
	output logic       ram_en,
	output logic       ram_oe,
	output logic       ram_we
);

	typedef enum logic [2:0] {
		st_idle,
		st_read1,
		st_read2,
		st_write1,
		st_write2
	} state_t;

	state_t state;
	word_t wdata;
	logic drive;

	assign ram_data = drive ? wdata : 'z;

	// Requester takes the bus value at the end of the second read cycle
	assign rd_data = ram_data;
	assign rd_done = (state == st_read2);
	assign wr_done = (state == st_write2);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			ram_en <= 1'b1;
			ram_oe <= 1'b1;
			ram_we <= 1'b1;
			drive <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					// Boot writes go first
					if (wr_req) begin
						ram_en <= 1'b0;
						ram_we <= 1'b0;
						drive <= 1'b1;
						state <= st_write1;
					end else if (rd_req) begin
						ram_en <= 1'b0;
						ram_oe <= 1'b0;
						state <= st_read1;
					end
				end
				st_read1: state <= st_read2;
				st_read2: begin
					ram_en <= 1'b1;
					ram_oe <= 1'b1;
					state <= st_idle;
				end
				st_write1: begin
					// Data held one more cycle past the rising write strobe
					ram_we <= 1'b1;
					state <= st_write2;
				end
				st_write2: begin
					ram_en <= 1'b1;
					drive <= 1'b0;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			if (wr_req) begin
				ram_addr <= wr_bus.addr;
				wdata <= wr_bus.wdata;
			end else if (rd_req) begin
				ram_addr <= rd_addr;
			end
		end
	end

endmodule

/* logic/status_display.sv */
`timescale 1ns/100ps

module status_display import boot_pkg::*; (
	input  logic      boot_done,
	input  ram_addr_t boot_addr,
	input  word_t     pc,
	output seg_t      seg_hi,
	output seg_t      seg_lo
);

	logic [7:0] show;

	function automatic seg_t hex_to_seg(input logic [3:0] nib);
		case (nib)
			4'h0: hex_to_seg = 7'h40;
			4'h1: hex_to_seg = 7'h79;
			4'h2: hex_to_seg = 7'h24;
			4'h3: hex_to_seg = 7'h30;
			4'h4: hex_to_seg = 7'h19;
			4'h5: hex_to_seg = 7'h12;
			4'h6: hex_to_seg = 7'h02;
			4'h7: hex_to_seg = 7'h78;
			4'h8: hex_to_seg = 7'h00;
			4'h9: hex_to_seg = 7'h10;
			4'ha: hex_to_seg = 7'h08;
			4'hb: hex_to_seg = 7'h03;
			4'hc: hex_to_seg = 7'h46;
			4'hd: hex_to_seg = 7'h21;
			4'he: hex_to_seg = 7'h06;
			default: hex_to_seg = 7'h0e;
		endcase
	endfunction

	// Copy progress first, then the fetch address
	assign show = boot_done ? pc[7:0] : boot_addr[7:0];

	assign seg_hi = hex_to_seg(show[7:4]);
	assign seg_lo = hex_to_seg(show[3:0]);

endmodule

/* logic/boot_fetch_top.sv */
`timescale 1ns/100ps

module boot_fetch_top import boot_pkg::*; #(
	parameter int BOOT_WORDS = 64,
	parameter int FLASH_BASE = 0,
	parameter int FLASH_WAIT = 3
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        hold,
	input  logic        set_pc,
	input  word_t       set_pc_addr,
	output logic        fetch_valid,
	output fetch_out_t  fetch,
	output logic        boot_done,
	output seg_t        seg_hi,
	output seg_t        seg_lo,
	output flash_addr_t flash_addr,
	input  word_t       flash_data,
	output logic        flash_ce,
	output logic        flash_oe,
	output ram_addr_t   ram_addr,
	inout  wire word_t  ram_data,
	output logic        ram_en,
	output logic        ram_oe,
	output logic        ram_we
);

	// Boot loader to flash reader
	logic        flash_req;
	flash_addr_t flash_addr_req;
	logic        flash_done;
	word_t       flash_word;

	// Requesters to arbiter
	logic      wr_req;
	mem_req_t  wr_bus;
	logic      wr_done;
	logic      rd_req;
	ram_addr_t rd_addr;
	logic      rd_done;
	word_t     rd_data;

	ram_addr_t boot_addr;
	word_t     pc;

	flash_reader #(
		.FLASH_WAIT(FLASH_WAIT)
	) reader_i (
		.clk(clk),
		.rst(rst),
		.flash_req(flash_req),
		.flash_addr_req(flash_addr_req),
		.flash_done(flash_done),
		.flash_word(flash_word),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe)
	);

	boot_loader #(
		.BOOT_WORDS(BOOT_WORDS),
		.FLASH_BASE(FLASH_BASE)
	) loader_i (
		.clk(clk),
		.rst(rst),
		.flash_req(flash_req),
		.flash_addr_req(flash_addr_req),
		.flash_done(flash_done),
		.flash_word(flash_word),
		.wr_req(wr_req),
		.wr_bus(wr_bus),
		.wr_done(wr_done),
		.boot_addr(boot_addr),
		.boot_done(boot_done)
	);

	inst_fetch fetch_i (
		.clk(clk),
		.rst(rst),
		.boot_done(boot_done),
		.hold(hold),
		.set_pc(set_pc),
		.set_pc_addr(set_pc_addr),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.fetch_valid(fetch_valid),
		.fetch(fetch),
		.pc(pc)
	);

	sram_arbiter arbiter_i (
		.clk(clk),
		.rst(rst),
		.wr_req(wr_req),
		.wr_bus(wr_bus),
		.wr_done(wr_done),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we)
	);

	status_display display_i (
		.boot_done(boot_done),
		.boot_addr(boot_addr),
		.pc(pc),
		.seg_hi(seg_hi),
		.seg_lo(seg_lo)
	);

endmodule

/* dv/flash_model.sv */
`timescale 1ns/100ps

module flash_model import boot_pkg::*; #(
	parameter int AW = 8
) (
	input  flash_addr_t addr,
	output word_t       data,
	input  logic        ce,
	input  logic        oe
);

	// Contents written by the testbench at time zero
	word_t mem [2**AW];

	// Bus floats unless the chip is selected for a read
	assign data = (!ce && !oe) ? mem[addr[AW-1:0]] : 'z;

endmodule

/* dv/sram_model.sv */
`timescale 1ns/100ps

module sram_model import boot_pkg::*; #(
	parameter int AW = 8
) (
	input  ram_addr_t  addr,
	inout  wire word_t data,
	input  logic       en,
	input  logic       oe,
	input  logic       we
);

	word_t mem [2**AW];

	// Read drive only with the write strobe inactive
	assign data = (!en && !oe && we) ? mem[addr[AW-1:0]] : 'z;

	// Write commits on the rising edge of the write strobe
	always @(posedge we) begin
		if (en === 1'b0)
			mem[addr[AW-1:0]] <= data;
	end

endmodule

/* dv/boot_fetch_tb.sv */
`timescale 1ns/100ps

module boot_fetch_tb import boot_pkg::*; ();

	localparam int BOOT_WORDS = 32;
	localparam int FLASH_BASE = 0;
	localparam int FLASH_WAIT = 3;
	localparam int FETCH_CYCLES = 8;
	localparam int ROWS = 6;

	// Lit segments in gfedcba order, digit F at the top
	localparam logic [16*7-1:0] SEG_LIT = {
		7'h71, 7'h79, 7'h5e, 7'h39, 7'h7c, 7'h77, 7'h6f, 7'h7f,
		7'h07, 7'h7d, 7'h6d, 7'h66, 7'h4f, 7'h5b, 7'h06, 7'h3f
	};

	logic        clk;
	logic        rst;
	logic        hold;
	logic        set_pc;
	word_t       set_pc_addr;
	logic        fetch_valid;
	fetch_out_t  fetch;
	logic        boot_done;
	seg_t        seg_hi;
	seg_t        seg_lo;
	flash_addr_t flash_addr;
	wire word_t  flash_data;
	logic        flash_ce;
	logic        flash_oe;
	ram_addr_t   ram_addr;
	wire word_t  ram_data;
	logic        ram_en;
	logic        ram_oe;
	logic        ram_we;

	word_t flash_image [256];
	logic [31:0] seed;
	string cur_test;
	int expected_pc;
	int fetch_seen;
	int base;
	logic monitor_on;
	logic table_loaded;

	// Stimulus table
	string row_name [ROWS];
	int    row_hold [ROWS];
	logic  row_jump [ROWS];
	int    row_target [ROWS];
	int    row_count [ROWS];

	boot_fetch_top #(
		.BOOT_WORDS(BOOT_WORDS),
		.FLASH_BASE(FLASH_BASE),
		.FLASH_WAIT(FLASH_WAIT)
	) dut_i (.*);

	flash_model #(.AW(8)) flash_i (
		.addr(flash_addr), .data(flash_data), .ce(flash_ce), .oe(flash_oe)
	);

	sram_model #(.AW(8)) sram_i (
		.addr(ram_addr), .data(ram_data), .en(ram_en), .oe(ram_oe), .we(ram_we)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [13:0] digits_for(input logic [7:0] b);
		return {~SEG_LIT[b[7:4]*7 +: 7], ~SEG_LIT[b[3:0]*7 +: 7]};
	endfunction

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_equal(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s: expected %h actual %h",
				cur_test, what, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic pulse_set_pc(input int target);
		set_pc = 1'b1;
		set_pc_addr = word_t'(target);
		expected_pc = target;
		next_cycle();
		set_pc = 1'b0;
	endtask

	task automatic wait_fetches(input int total, input int limit);
		int cycles;
		cycles = 0;
		while (fetch_seen < total) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("%s: no fetch_valid within %0d cycles", cur_test, limit);
				stop_with_failure();
			end
		end
		#1;
	endtask

	task automatic set_row(input int idx, input string name, input int hold_len,
			input logic jump, input int target, input int count);
		row_name[idx] = name;
		row_hold[idx] = hold_len;
		row_jump[idx] = jump;
		row_target[idx] = target;
		row_count[idx] = count;
	endtask

	// Output monitor, sampled away from the rising edge
	always @(negedge clk) begin
		if (monitor_on) begin
			if (!boot_done) begin
				check_equal("fetch_valid before boot", 0, fetch_valid);
				if (!flash_ce)
					check_equal("digits at flash read", digits_for(8'(flash_addr - FLASH_BASE)),
						{seg_hi, seg_lo});
				if (!ram_we)
					check_equal("digits at sram write", digits_for(ram_addr[7:0]),
						{seg_hi, seg_lo});
			end else if (fetch_valid) begin
				check_equal("fetch_valid while held", 0, hold);
				check_equal("fetch pc", expected_pc, fetch.pc);
				check_equal("fetch inst", flash_image[FLASH_BASE + expected_pc], fetch.inst);
				// PC already points past the issued word
				check_equal("digits show pc", digits_for(8'(expected_pc + 1)), {seg_hi, seg_lo});
				expected_pc = expected_pc + 1;
				fetch_seen = fetch_seen + 1;
			end
		end
	end

	initial begin
		int limit;
		wait (table_loaded === 1'b1);
		limit = BOOT_WORDS * (FLASH_WAIT + 12) + 40;
		for (int r = 0; r < ROWS; r++)
			limit += row_count[r] * FETCH_CYCLES + row_hold[r] + 20;
		repeat (limit) @(posedge clk);
		$display("Run did not finish within %0d clock cycles", limit);
		stop_with_failure();
	end

	initial begin
		int cycles;
		clk = 1'b0;
		rst = 1'b1;
		hold = 1'b0;
		set_pc = 1'b0;
		set_pc_addr = '0;
		monitor_on = 1'b0;
		table_loaded = 1'b0;
		expected_pc = 0;
		fetch_seen = 0;
		cur_test = "reset";
		seed = 32'h28561df4;
		for (int i = 0; i < 256; i++) begin
			seed = lcg_next(seed);
			flash_image[i] = seed[31:16];
			flash_i.mem[i] = flash_image[i];
		end

		set_row(0, "linear", 0, 1'b0, 0, 6);
		set_row(1, "hold", 12, 1'b0, 0, 5);
		set_row(2, "jump", 0, 1'b1, 20, 4);
		set_row(3, "hold_jump", 10, 1'b1, 8, 5);
		set_row(4, "jump_back", 0, 1'b1, 2, 3);
		set_row(5, "hold_short", 3, 1'b0, 0, 4);
		table_loaded = 1'b1;

		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_equal("fetch_valid", 0, fetch_valid);
		check_equal("boot_done", 0, boot_done);
		check_equal("flash_ce", 1, flash_ce);
		check_equal("flash_oe", 1, flash_oe);
		check_equal("ram_en", 1, ram_en);
		check_equal("ram_oe", 1, ram_oe);
		check_equal("ram_we", 1, ram_we);
		check_equal("digits", digits_for(8'h00), {seg_hi, seg_lo});
		monitor_on = 1'b1;

		cur_test = "boot";
		cycles = 0;
		while (!boot_done) begin
			@(negedge clk);
			cycles++;
			if (cycles > BOOT_WORDS * (FLASH_WAIT + 12)) begin
				$display("boot_done never rose after %0d cycles", cycles);
				stop_with_failure();
			end
		end
		for (int i = 0; i < BOOT_WORDS; i++)
			check_equal($sformatf("sram word %0d", i), flash_image[FLASH_BASE + i],
				sram_i.mem[i]);
		next_cycle();

		for (int r = 0; r < ROWS; r++) begin
			cur_test = row_name[r];
			if (row_hold[r] > 0) begin
				hold = 1'b1;
				if (row_jump[r]) begin
					repeat (row_hold[r] / 2) next_cycle();
					pulse_set_pc(row_target[r]);
					repeat (row_hold[r] - row_hold[r] / 2) next_cycle();
				end else begin
					repeat (row_hold[r]) next_cycle();
				end
				hold = 1'b0;
			end else if (row_jump[r]) begin
				pulse_set_pc(row_target[r]);
			end
			base = fetch_seen;
			wait_fetches(base + row_count[r], row_count[r] * FETCH_CYCLES + 10);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

/* list.f */
logic/boot_pkg.sv
logic/flash_reader.sv
logic/boot_loader.sv
logic/inst_fetch.sv
logic/sram_arbiter.sv
logic/status_display.sv
logic/boot_fetch_top.sv
dv/flash_model.sv
dv/sram_model.sv
dv/boot_fetch_tb.sv
